//--- source/rv_core_pkg.sv
package rv_core_pkg;

    // widths
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RAM_BASE   = 64'h8000_0000; // first fetch
    localparam logic [XLEN-1:0] INSTR_STEP = 64'd4;
    localparam logic [ILEN-1:0] NOP_INSTR  = 32'h0000_0001; // decodes as illegal, does nothing

    // major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_W     = 7'b0111011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;

    typedef enum logic [3:0] {
        CLASS_LUI, CLASS_AUIPC, CLASS_ALU, CLASS_ALU_W, CLASS_LOAD,
        CLASS_STORE, CLASS_BRANCH, CLASS_JAL, CLASS_JALR, CLASS_NONE
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // encodings follow branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

    typedef enum logic {LOAD_IDLE, LOAD_WAIT} load_state_e;

    typedef struct packed {
        instr_class_e            instr_class;
        alu_op_e                 alu_op;
        branch_cond_e            branch_cond;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs1;
        logic [REG_ADDR_W-1:0]   rs2;
        logic [XLEN-1:0]         imm;
        logic [2:0]              funct3;    // load width code
        logic                    use_imm;   // imm as second operand
    } decoded_instr_t;

    typedef struct packed {
        logic                    we;
        logic [REG_ADDR_W-1:0]   rd;
        logic [XLEN-1:0]         value;
        logic                    load_pending; // write bus data on done
        logic [2:0]              load_width;
    } writeback_t;

    typedef struct packed {
        logic                    take;
        logic [XLEN-1:0]         target;
    } redirect_t;

endpackage

//--- source/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [ILEN-1:0]  instruction_i,
    input  logic             flush_i,
    output decoded_instr_t   decoded_o
);

    logic [ILEN-1:0] ir;          // instruction register, holds word at pc-4
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            alt_op;      // sub / sra select
    logic            r_legal;
    logic            imm_shift_ok;
    logic            w_funct_ok;
    alu_op_e         alu_sel;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= NOP_INSTR;
        end else begin
            ir <= instruction_i; // fetch every cycle
        end
    end

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    // immediates, all sign extended from bit 31
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_j = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // only register forms and right shifts look at funct7
    assign alt_op  = funct7[5] && (opcode == OPC_OP || opcode == OPC_OP_W || funct3 == 3'b101);
    assign r_legal = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign w_funct_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);

    // rv64 shamt is 6 bits, so funct7[0] belongs to it
    always_comb begin
        case (funct3)
            3'b001:  imm_shift_ok = (funct7[6:1] == 6'b000000);
            3'b101:  imm_shift_ok = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
            default: imm_shift_ok = 1'b1;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_sel = alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    end

    always_comb begin
        decoded_o.instr_class = CLASS_NONE;
        decoded_o.alu_op      = alu_sel;
        decoded_o.branch_cond = branch_cond_e'(funct3);
        decoded_o.rd          = ir[11:7];
        decoded_o.rs1         = ir[19:15];
        decoded_o.rs2         = ir[24:20];
        decoded_o.imm         = imm_i;      // most common
        decoded_o.funct3      = funct3;
        decoded_o.use_imm     = 1'b1;
        case (opcode)
            OPC_LUI: begin
                decoded_o.instr_class = CLASS_LUI;
                decoded_o.imm         = imm_u;
            end
            OPC_AUIPC: begin
                decoded_o.instr_class = CLASS_AUIPC;
                decoded_o.imm         = imm_u;
            end
            OPC_OP_IMM: begin
                if (imm_shift_ok) decoded_o.instr_class = CLASS_ALU;
            end
            OPC_OP_IMM_W: begin
                // addiw, slliw, srliw, sraiw
                if (w_funct_ok && (funct3 == 3'b000 || r_legal)) decoded_o.instr_class = CLASS_ALU_W;
            end
            OPC_OP: begin
                decoded_o.use_imm = 1'b0;
                if (r_legal) decoded_o.instr_class = CLASS_ALU;
            end
            OPC_OP_W: begin
                decoded_o.use_imm = 1'b0;
                if (r_legal && w_funct_ok) decoded_o.instr_class = CLASS_ALU_W;
            end
            OPC_LOAD: begin
                if (funct3 != 3'b111) decoded_o.instr_class = CLASS_LOAD; // no 111 width
            end
            OPC_STORE: begin
                decoded_o.imm = imm_s;
                if (funct3 == 3'b010) decoded_o.instr_class = CLASS_STORE; // sw only
            end
            OPC_BRANCH: begin
                decoded_o.imm     = imm_b;
                decoded_o.use_imm = 1'b0;
                if (funct3[2:1] != 2'b01) decoded_o.instr_class = CLASS_BRANCH;
            end
            OPC_JAL: begin
                decoded_o.instr_class = CLASS_JAL;
                decoded_o.imm         = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) decoded_o.instr_class = CLASS_JALR;
            end
            default: ; // unknown stays none
        endcase
        if (flush_i) decoded_o.instr_class = CLASS_NONE; // bubble after change of flow
    end

endmodule

//--- source/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  decoded_instr_t   decoded_i,
    input  logic [XLEN-1:0]  rs1_value_i,
    input  logic [XLEN-1:0]  rs2_value_i,
    input  logic [XLEN-1:0]  pc_i,
    input  logic             bus_read_done_i,
    output writeback_t       writeback_o,
    output redirect_t        redirect_o,
    output logic             hold_o,
    output logic [XLEN-1:0]  bus_address_o,
    output logic [XLEN-1:0]  bus_write_data_o,
    output logic             bus_write_enable_o,
    output logic             bus_read_enable_o,
    output logic [2:0]       bus_read_type_o
);

    load_state_e           load_state;
    logic [REG_ADDR_W-1:0] load_rd;      // destination kept across the wait
    logic [XLEN-1:0]       instr_pc;     // address of the executing word
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       addr_sum;     // load, store and jalr address
    logic [XLEN-1:0]       alu_result;
    logic [31:0]           word_raw;
    logic [XLEN-1:0]       word_result;
    logic                  branch_taken;

    assign instr_pc  = pc_i - INSTR_STEP; // pc already points one past
    assign operand_b = decoded_i.use_imm ? decoded_i.imm : rs2_value_i;
    assign addr_sum  = rs1_value_i + decoded_i.imm;

    always_comb begin
        case (decoded_i.alu_op)
            ALU_ADD:  alu_result = rs1_value_i + operand_b;
            ALU_SUB:  alu_result = rs1_value_i - operand_b;
            ALU_XOR:  alu_result = rs1_value_i ^ operand_b;
            ALU_OR:   alu_result = rs1_value_i | operand_b;
            ALU_AND:  alu_result = rs1_value_i & operand_b;
            ALU_SLL:  alu_result = rs1_value_i << operand_b[5:0];
            ALU_SRL:  alu_result = rs1_value_i >> operand_b[5:0];
            ALU_SRA:  alu_result = $signed(rs1_value_i) >>> operand_b[5:0];
            ALU_SLT:  alu_result = {{XLEN-1{1'b0}}, $signed(rs1_value_i) < $signed(operand_b)};
            default:  alu_result = {{XLEN-1{1'b0}}, rs1_value_i < operand_b}; // sltu
        endcase
    end

    // word ops, 5 bit shift amount
    always_comb begin
        case (decoded_i.alu_op)
            ALU_ADD: word_raw = rs1_value_i[31:0] + operand_b[31:0];
            ALU_SUB: word_raw = rs1_value_i[31:0] - operand_b[31:0];
            ALU_SLL: word_raw = rs1_value_i[31:0] << operand_b[4:0];
            ALU_SRL: word_raw = rs1_value_i[31:0] >> operand_b[4:0];
            ALU_SRA: word_raw = $signed(rs1_value_i[31:0]) >>> operand_b[4:0];
            default: word_raw = '0;
        endcase
    end
    assign word_result = {{32{word_raw[31]}}, word_raw};

    always_comb begin
        case (decoded_i.branch_cond)
            BR_EQ:   branch_taken = (rs1_value_i == rs2_value_i);
            BR_NE:   branch_taken = (rs1_value_i != rs2_value_i);
            BR_LT:   branch_taken = ($signed(rs1_value_i) < $signed(rs2_value_i));
            BR_GE:   branch_taken = ($signed(rs1_value_i) >= $signed(rs2_value_i));
            BR_LTU:  branch_taken = (rs1_value_i < rs2_value_i);
            default: branch_taken = (rs1_value_i >= rs2_value_i); // geu
        endcase
    end

    always_comb begin
        writeback_o = '0;
        redirect_o  = '0;
        hold_o      = 1'b0;
        writeback_o.rd = decoded_i.rd;
        if (load_state == LOAD_WAIT) begin
            // decode is flushed here, the load owns the cycle
            writeback_o.rd           = load_rd;
            writeback_o.load_pending = 1'b1;
            writeback_o.load_width   = bus_read_type_o;
            hold_o                   = !bus_read_done_i;
        end else begin
            case (decoded_i.instr_class)
                CLASS_LUI:   {writeback_o.we, writeback_o.value} = {1'b1, decoded_i.imm};
                CLASS_AUIPC: {writeback_o.we, writeback_o.value} = {1'b1, instr_pc + decoded_i.imm};
                CLASS_ALU:   {writeback_o.we, writeback_o.value} = {1'b1, alu_result};
                CLASS_ALU_W: {writeback_o.we, writeback_o.value} = {1'b1, word_result};
                CLASS_JAL: begin
                    {writeback_o.we, writeback_o.value} = {1'b1, pc_i}; // return address
                    redirect_o = '{take: 1'b1, target: instr_pc + decoded_i.imm};
                end
                CLASS_JALR: begin
                    {writeback_o.we, writeback_o.value} = {1'b1, pc_i};
                    redirect_o = '{take: 1'b1, target: {addr_sum[XLEN-1:1], 1'b0}};
                end
                CLASS_BRANCH: redirect_o = '{take: branch_taken, target: instr_pc + decoded_i.imm};
                CLASS_LOAD, CLASS_STORE: hold_o = 1'b1; // refetch the next word after the bubble
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            load_state         <= LOAD_IDLE;
            bus_address_o      <= RAM_BASE;
            bus_write_data_o   <= '0;
            bus_write_enable_o <= 1'b0;
            bus_read_enable_o  <= 1'b0;
            bus_read_type_o    <= '0;
        end else begin
            bus_write_enable_o <= 1'b0; // one cycle write pulse
            case (load_state)
                LOAD_IDLE: begin
                    if (decoded_i.instr_class == CLASS_LOAD) begin
                        bus_address_o     <= addr_sum;
                        bus_read_enable_o <= 1'b1;
                        bus_read_type_o   <= decoded_i.funct3;
                        load_state        <= LOAD_WAIT;
                    end else if (decoded_i.instr_class == CLASS_STORE) begin
                        bus_address_o      <= addr_sum;
                        bus_write_data_o   <= {32'b0, rs2_value_i[31:0]};
                        bus_write_enable_o <= 1'b1;
                    end
                end
                default: begin
                    // request stays stable until done
                    if (bus_read_done_i) begin
                        bus_read_enable_o <= 1'b0;
                        load_state        <= LOAD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_state == LOAD_IDLE && decoded_i.instr_class == CLASS_LOAD) load_rd <= decoded_i.rd;
    end

endmodule

//--- source/rv_result.sv
`timescale 1ns/1ns

module rv_result import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  writeback_t            writeback_i,
    input  logic [XLEN-1:0]       bus_read_data_i,
    input  logic                  bus_read_done_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs1_value_o,
    output logic [XLEN-1:0]       rs2_value_o
);

    logic [XLEN-1:0] regs [1:31]; // x0 not stored
    logic [XLEN-1:0] load_value;
    logic [XLEN-1:0] wr_value;
    logic            wr_en;

    // extend by width code, same encoding as load funct3
    always_comb begin
        case (writeback_i.load_width)
            3'b000:  load_value = {{56{bus_read_data_i[7]}}, bus_read_data_i[7:0]};   // lb
            3'b100:  load_value = {56'b0, bus_read_data_i[7:0]};                      // lbu
            3'b001:  load_value = {{48{bus_read_data_i[15]}}, bus_read_data_i[15:0]}; // lh
            3'b101:  load_value = {48'b0, bus_read_data_i[15:0]};                     // lhu
            3'b010:  load_value = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]}; // lw
            3'b110:  load_value = {32'b0, bus_read_data_i[31:0]};                     // lwu
            default: load_value = bus_read_data_i;                                    // ld
        endcase
    end

    assign wr_en    = writeback_i.we || (writeback_i.load_pending && bus_read_done_i);
    assign wr_value = writeback_i.load_pending ? load_value : writeback_i.value;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && writeback_i.rd != '0) begin
            regs[writeback_i.rd] <= wr_value; // writes to x0 dropped
        end
    end

    // combinational read ports, x0 reads zero
    assign rs1_value_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_value_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- source/rv_flow_control.sv
`timescale 1ns/1ns

module rv_flow_control import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  redirect_t        redirect_i,
    input  logic             hold_i,
    output logic [XLEN-1:0]  pc_o,
    output logic             flush_o
);

    logic            bubble;    // kills the word fetched under a change of flow
    logic [XLEN-1:0] pc_plus;

    assign pc_plus = pc_o + INSTR_STEP;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o   <= RAM_BASE;
            bubble <= 1'b0;
        end else begin
            bubble <= redirect_i.take || hold_i; // clears itself next cycle
            if (redirect_i.take) begin
                pc_o <= redirect_i.target;
            end else if (hold_i) begin
                pc_o <= pc_plus - INSTR_STEP; // refetch same word
            end else begin
                pc_o <= pc_plus;
            end
        end
    end

    assign flush_o = bubble;

endmodule

//--- source/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [ILEN-1:0]  instruction_i,
    output logic [XLEN-1:0]  pc_o,
    output logic [XLEN-1:0]  bus_address_o,
    output logic [XLEN-1:0]  bus_write_data_o,
    output logic             bus_write_enable_o,
    output logic             bus_read_enable_o,
    output logic [2:0]       bus_read_type_o,
    input  logic             bus_read_done_i,
    input  logic [XLEN-1:0]  bus_read_data_i
);

    decoded_instr_t  decoded;
    writeback_t      writeback;
    redirect_t       redirect;
    logic            hold;
    logic            flush;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;

    rv_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .instruction_i (instruction_i),
        .flush_i       (flush),
        .decoded_o     (decoded)
    );

    rv_execute u_execute (
        .clk                (clk),
        .reset              (reset),
        .decoded_i          (decoded),
        .rs1_value_i        (rs1_value),
        .rs2_value_i        (rs2_value),
        .pc_i               (pc_o),
        .bus_read_done_i    (bus_read_done_i),
        .writeback_o        (writeback),
        .redirect_o         (redirect),
        .hold_o             (hold),
        .bus_address_o      (bus_address_o),
        .bus_write_data_o   (bus_write_data_o),
        .bus_write_enable_o (bus_write_enable_o),
        .bus_read_enable_o  (bus_read_enable_o),
        .bus_read_type_o    (bus_read_type_o)
    );

    rv_result u_result (
        .clk             (clk),
        .reset           (reset),
        .writeback_i     (writeback),
        .bus_read_data_i (bus_read_data_i),
        .bus_read_done_i (bus_read_done_i),
        .rs1_addr_i      (decoded.rs1),
        .rs2_addr_i      (decoded.rs2),
        .rs1_value_o     (rs1_value),
        .rs2_value_o     (rs2_value)
    );

    rv_flow_control u_flow_control (
        .clk        (clk),
        .reset      (reset),
        .redirect_i (redirect),
        .hold_i     (hold),
        .pc_o       (pc_o),
        .flush_o    (flush)
    );

endmodule

//--- dv/rv_core_program.svh
task automatic emit(input logic [31:0] word);
    program_q.push_back(word);
endtask

function automatic logic [63:0] next_pc();
    return RAM_BASE + 64'(program_q.size()) * 4;
endfunction

// sw rs2 into the next result slot and note what must land there
task automatic store_check(input int rs2, input logic [31:0] value);
    int slot;
    slot = expect_q.size();
    emit(s_type(slot * 4, rs2, 11, 3'b010));
    expect_q.push_back('{addr: STORE_BASE + 64'(slot * 4), data: value});
endtask

// a taken branch skips a stray store and a fall-through bumps x20
task automatic branch_case(input int f3, input int rs1, input int rs2, input bit taken);
    emit(b_type(8, rs2, rs1, f3));
    if (taken) emit(s_type('h7fc, 0, 11, 3'b010)); // must never reach the bus
    else emit(i_type(1, 20, 0, 20, OPC_OP_IMM));
endtask

// x10 holds the data area base
task automatic load_check(input int f3, input int off, input logic [31:0] value);
    emit(i_type(off, 10, f3, 16, OPC_LOAD));
    load_q.push_back('{addr: DATA_BASE + 64'(off), rtype: f3[2:0]});
    store_check(16, value);
endtask

task automatic build_program();
    logic [63:0] jal_pc;
    logic [63:0] jalr_pc;
    logic [63:0] auipc_pc;
    emit(u_type('h2, 11, OPC_LUI));             // x11 store area
    emit(u_type('h1, 10, OPC_LUI));             // x10 data area
    emit(i_type(-5, 0, 0, 6, OPC_OP_IMM));      // x6 = -5
    emit(i_type(3, 0, 0, 7, OPC_OP_IMM));       // x7 = 3
    // immediate forms
    emit(u_type('h12345, 5, OPC_LUI));
    store_check(5, 32'h1234_5000);
    emit(i_type('h678, 5, 0, 5, OPC_OP_IMM));
    store_check(5, 32'h1234_5678);
    emit(i_type(-1, 5, 4, 8, OPC_OP_IMM));      // xori
    store_check(8, 32'hedcb_a987);
    emit(i_type('h0f0, 5, 6, 8, OPC_OP_IMM));   // ori
    store_check(8, 32'h1234_56f8);
    emit(i_type('h0ff, 5, 7, 8, OPC_OP_IMM));   // andi
    store_check(8, 32'h0000_0078);
    emit(i_type(-4, 6, 2, 8, OPC_OP_IMM));      // slti -5 < -4
    store_check(8, 32'h1);
    emit(i_type(5, 6, 3, 8, OPC_OP_IMM));       // sltiu sees -5 as huge unsigned
    store_check(8, 32'h0);
    // register forms with upper words seen through srai 32
    emit(r_type(0, 6, 5, 0, 8, OPC_OP));
    store_check(8, 32'h1234_5673);
    emit(r_type('h20, 6, 7, 0, 8, OPC_OP));     // 3 - (-5)
    store_check(8, 32'h8);
    emit(i_type(33, 0, 0, 9, OPC_OP_IMM));
    emit(r_type(0, 9, 7, 1, 8, OPC_OP));        // 3 << 33
    emit(i_type('h420, 8, 5, 8, OPC_OP_IMM));
    store_check(8, 32'h6);
    emit(r_type(0, 9, 6, 5, 8, OPC_OP));        // srl by 33
    store_check(8, 32'h7fff_ffff);
    emit(u_type('h80000, 13, OPC_LUI));         // x13 = ffff_ffff_8000_0000
    emit(r_type('h20, 7, 13, 5, 8, OPC_OP));    // sra
    store_check(8, 32'hf000_0000);
    emit(i_type('h420, 8, 5, 8, OPC_OP_IMM));
    store_check(8, 32'hffff_ffff);
    emit(r_type(0, 7, 6, 2, 8, OPC_OP));        // slt
    store_check(8, 32'h1);
    emit(r_type(0, 7, 6, 3, 8, OPC_OP));        // sltu
    store_check(8, 32'h0);
    emit(u_type('h7ffff, 14, OPC_LUI));
    emit(r_type(0, 14, 14, 0, 8, OPC_OP_W));    // addw overflows into the sign
    store_check(8, 32'hffff_e000);
    emit(i_type('h420, 8, 5, 8, OPC_OP_IMM));
    store_check(8, 32'hffff_ffff);
    emit(r_type(0, 14, 14, 0, 8, OPC_OP));      // plain add keeps upper zero
    emit(i_type('h420, 8, 5, 8, OPC_OP_IMM));
    store_check(8, 32'h0);
    emit(r_type('h20, 7, 6, 0, 8, OPC_OP_W));   // subw
    store_check(8, 32'hffff_fff8);
    emit(i_type(30, 0, 0, 15, OPC_OP_IMM));
    emit(r_type(0, 15, 7, 1, 8, OPC_OP_W));     // sllw 3 << 30
    emit(i_type('h420, 8, 5, 8, OPC_OP_IMM));
    store_check(8, 32'hffff_ffff);
    emit(r_type(0, 7, 13, 5, 8, OPC_OP_W));     // srlw
    store_check(8, 32'h1000_0000);
    emit(r_type('h20, 7, 13, 5, 8, OPC_OP_W));  // sraw
    store_check(8, 32'hf000_0000);
    emit(i_type('h420, 8, 5, 8, OPC_OP_IMM));
    store_check(8, 32'hffff_ffff);
    emit(i_type('h404, 13, 5, 8, OPC_OP_IMM_W)); // sraiw by 4
    store_check(8, 32'hf800_0000);
    // beq bne blt bgeu branches
    branch_case(0, 7, 7, 1);
    branch_case(0, 6, 7, 0);
    branch_case(1, 6, 7, 1);
    branch_case(1, 7, 7, 0);
    branch_case(4, 6, 7, 1);
    branch_case(4, 7, 6, 0);
    branch_case(7, 6, 7, 1);
    branch_case(7, 7, 6, 0);
    store_check(20, 32'h4);                     // four fall-throughs
    // jal into a subroutine and jalr back
    jal_pc = next_pc() + 4;
    emit(j_type(12, 1));
    store_check(1, jal_pc[31:0]);
    emit(j_type(12, 0));                        // hop over the subroutine
    emit(i_type(77, 0, 0, 3, OPC_OP_IMM));
    jalr_pc = next_pc() + 4;
    emit(i_type(0, 1, 0, 2, OPC_JALR));
    store_check(3, 32'd77);
    store_check(2, jalr_pc[31:0]);
    // loads from data bytes b4 a5 76 84 c3 d2 e1 f0
    load_check(0, 0, 32'hffff_ffb4);
    load_check(4, 0, 32'h0000_00b4);
    load_check(1, 0, 32'hffff_a5b4);
    load_check(5, 0, 32'h0000_a5b4);
    load_check(0, 5, 32'hffff_ffd2);
    load_check(2, 0, 32'h8476_a5b4);
    emit(i_type('h420, 16, 5, 16, OPC_OP_IMM));
    store_check(16, 32'hffff_ffff);
    load_check(6, 0, 32'h8476_a5b4);
    emit(i_type('h420, 16, 5, 16, OPC_OP_IMM));
    store_check(16, 32'h0);
    load_check(3, 0, 32'h8476_a5b4);
    emit(i_type(32, 16, 5, 16, OPC_OP_IMM));    // srli 32
    store_check(16, 32'hf0e1_d2c3);
    // auipc and x0
    auipc_pc = next_pc() + 64'h1000;
    emit(u_type('h1, 17, OPC_AUIPC));
    store_check(17, auipc_pc[31:0]);
    emit(i_type(55, 0, 0, 0, OPC_OP_IMM));
    store_check(0, 32'h0);
    emit(j_type(0, 0));                         // park
endtask

//--- dv/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb import rv_core_pkg::*; ();

    localparam int          IMEM_WORDS = 256;
    localparam logic [31:0] SELF_JUMP  = 32'h0000_006f; // jal x0 back to itself
    localparam logic [63:0] DATA_BASE  = 64'h1000;
    localparam logic [63:0] STORE_BASE = 64'h2000;
    localparam logic [63:0] DATA_DWORD = 64'hf0e1_d2c3_8476_a5b4;

    typedef struct packed {
        logic [63:0] addr;
        logic [31:0] data;
    } store_t;

    typedef struct packed {
        logic [63:0] addr;
        logic [2:0]  rtype;
    } load_req_t;

    logic            clk;
    logic            reset;
    logic [31:0]     instruction_i;
    logic [63:0]     pc_o;
    logic [63:0]     bus_address_o;
    logic [63:0]     bus_write_data_o;
    logic            bus_write_enable_o;
    logic            bus_read_enable_o;
    logic [2:0]      bus_read_type_o;
    logic            bus_read_done_i;
    logic [63:0]     bus_read_data_i;

    logic [31:0]     program_q[$];
    store_t          expect_q[$];
    load_req_t       load_q[$];      // loads in program order
    load_req_t       next_load;
    logic [31:0]     imem [0:IMEM_WORDS-1];
    logic [7:0]      data_mem [logic [63:0]];
    logic [63:0]     fetch_index;
    integer          seed = 32'h04f0_5b22;
    int              cycles = 0;
    int              limit = 1000;
    int              pass_count = 0;
    int              fail_count = 0;
    int              stores_done = 0;
    int              handshake_errors = 0;
    bit              timed_out = 0;
    bit              busy = 0;       // read request outstanding
    int              wait_cnt;
    logic [63:0]     req_addr;
    logic [2:0]      req_type;

    rv_core_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (reset) cycles++;
    end

    // instruction side answers the pc at once
    assign fetch_index   = (pc_o - RAM_BASE) >> 2;
    assign instruction_i = (fetch_index < IMEM_WORDS) ? imem[fetch_index] : SELF_JUMP;

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd, input logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int imm20, input int rd, input logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    `include "rv_core_program.svh"

    // eight bytes little endian from the request address
    function automatic logic [63:0] read_dword(input logic [63:0] addr);
        logic [63:0] value;
        for (int j = 0; j < 8; j++) begin
            value[8*j +: 8] = data_mem.exists(addr + j) ? data_mem[addr + j] : 8'h00;
        end
        return value;
    endfunction

    // outputs while reset is still held
    task automatic check_reset_state();
        bit ok;
        ok = 1;
        assert (pc_o == RAM_BASE) else begin
            $display("FAILED reset pc_o got %h expected %h", pc_o, RAM_BASE);
            ok = 0;
        end
        assert (bus_address_o == RAM_BASE) else begin
            $display("FAILED reset bus_address_o got %h expected %h", bus_address_o, RAM_BASE);
            ok = 0;
        end
        assert (!bus_read_enable_o && !bus_write_enable_o) else begin
            $display("read or write enable is high during reset");
            ok = 0;
        end
        if (ok) pass_count++;
        else fail_count++;
        $display("reset state: %s", ok ? "pass" : "fail");
    endtask

    // data side gives done after 0 to 3 cycles
    always @(posedge clk) begin
        #1;
        if (bus_read_done_i) begin
            bus_read_done_i = 1'b0; // enable dropped on that edge
            busy            = 0;
        end else if (busy || bus_read_enable_o) begin
            if (!busy) begin
                busy     = 1;
                req_addr = bus_address_o;
                req_type = bus_read_type_o;
                wait_cnt = $unsigned($random(seed)) % 4;
                if (load_q.size() == 0) begin
                    $display("read request at %h issued with no load left in the program",
                             bus_address_o);
                    handshake_errors++;
                end else begin
                    next_load = load_q.pop_front();
                    assert (bus_address_o == next_load.addr) else begin
                        $display("FAILED load bus_address_o got %h expected %h",
                                 bus_address_o, next_load.addr);
                        handshake_errors++;
                    end
                    assert (bus_read_type_o == next_load.rtype) else begin
                        $display("FAILED load bus_read_type_o got %h expected %h",
                                 bus_read_type_o, next_load.rtype);
                        handshake_errors++;
                    end
                end
            end
            assert (bus_read_enable_o && bus_address_o == req_addr && bus_read_type_o == req_type)
            else begin
                $display("read request at %h was dropped or changed before done", req_addr);
                handshake_errors++;
            end
            if (wait_cnt == 0) begin
                bus_read_done_i = 1'b1;
                bus_read_data_i = read_dword(req_addr);
            end else begin
                wait_cnt--;
            end
        end
    end

    initial begin
        bit ok;
        clk             = 1'b0;
        reset           = 1'b0;
        bus_read_done_i = 1'b0;
        bus_read_data_i = '0;
        build_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < program_q.size()) ? program_q[i] : SELF_JUMP;
        end
        for (int j = 0; j < 8; j++) begin
            data_mem[DATA_BASE + j] = DATA_DWORD[8*j +: 8];
        end
        limit = program_q.size() * 8 + 200; // generous per instruction
        repeat (10) @(posedge clk);
        #1;
        check_reset_state();
        reset = 1'b1;
        foreach (expect_q[i]) begin
            @(negedge clk);
            while (!bus_write_enable_o && cycles < limit) @(negedge clk);
            if (cycles >= limit) begin
                timed_out = 1;
                break;
            end
            ok = 1;
            assert (bus_address_o == expect_q[i].addr) else begin
                $display("FAILED store %0d bus_address_o got %h expected %h",
                         i, bus_address_o, expect_q[i].addr);
                ok = 0;
            end
            assert (bus_write_data_o[31:0] == expect_q[i].data) else begin
                $display("FAILED store %0d bus_write_data_o got %h expected %h",
                         i, bus_write_data_o[31:0], expect_q[i].data);
                ok = 0;
            end
            if (ok) pass_count++;
            else fail_count++;
            stores_done++;
            $display("store %0d to %h: %s", i, expect_q[i].addr, ok ? "pass" : "fail");
        end
        if (timed_out) begin
            $display("timeout after %0d cycles, only %0d of %0d expected stores arrived",
                     cycles, stores_done, expect_q.size());
        end else if (load_q.size() != 0) begin
            $display("%0d expected loads never reached the bus", load_q.size());
            handshake_errors++;
        end
        $display("%0d checks passed, %0d failed, %0d read errors",
                 pass_count, fail_count, handshake_errors);
        if (fail_count == 0 && handshake_errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- Bender.yml
package:
  name: rv_core

sources:
  - source/rv_core_pkg.sv
  - source/rv_decode.sv
  - source/rv_execute.sv
  - source/rv_result.sv
  - source/rv_flow_control.sv
  - source/rv_core_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rv_core_tb.sv

//--- compile.f
+incdir+dv
source/rv_core_pkg.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_flow_control.sv
source/rv_core_top.sv
dv/rv_core_tb.sv
